/* periph_pkg.sv */
// Peripheral subsystem package
// Bus widths, slot map, register offsets and the APB-style request/response structs

package periph_pkg;

    // Bus sizes
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // --------------------
    // Slot decoding
    // --------------------
    localparam int SlotLsb = 12;
    localparam int SlotMsb = 15;

    localparam logic [SlotMsb-SlotLsb:0] SlotPlic  = 'd0;
    localparam logic [SlotMsb-SlotLsb:0] SlotGpio  = 'd1;
    localparam logic [SlotMsb-SlotLsb:0] SlotTimer = 'd2;

    localparam logic [DataWidth-1:0] ErrorData = 32'hDEADBEEF; // Unmapped slot pattern

    // --------------------
    // Interrupt controller
    // --------------------
    localparam int NumSources  = 3;  // IDs 1..3, 0 is no interrupt
    localparam int SrcExt      = 1;
    localparam int SrcTimer0   = 2;
    localparam int SrcTimer1   = 3;
    localparam int NumTargets  = 2;
    localparam int PrioWidth   = 2;
    localparam int MaxPriority = 3;
    localparam int SrcIdWidth  = 2;

    localparam int PlicPrioBase     = 'h000; // 4 bytes per source ID
    localparam int PlicPendingOff   = 'h080;
    localparam int PlicEnableBase   = 'h100; // 4 bytes per target
    localparam int PlicThreshBase   = 'h200;
    localparam int PlicClaimBase    = 'h204;
    localparam int PlicTargetStride = 'h010; // Threshold and claim per target

    // Timers and GPIO
    localparam int NumTimers = 2;
    localparam int NumGpio   = 8;

    localparam int GpioOutOff = 'h0;
    localparam int GpioInOff  = 'h4;

    localparam int TimerStride     = 'h10;
    localparam int TimerCountOff   = 'h0;
    localparam int TimerCompareOff = 'h4;
    localparam int TimerCtrlOff    = 'h8; // Bit 0 is the enable
    localparam int TimerStatusOff  = 'hC;

    // --------------------
    // Bus types
    // --------------------
    typedef struct packed {
        logic                 sel;
        logic                 enable;
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 ready;
        logic                 slverr;
    } apb_resp_t;

endpackage

/* periph_apb_decode.sv */
// Slot decoder for the peripheral bus
// Gates sel per slave, muxes read data back, answers unmapped slots with an error

module periph_apb_decode (
    input  periph_pkg::apb_req_t                 bus_req_i,
    output periph_pkg::apb_resp_t                bus_resp_o,
    output periph_pkg::apb_req_t                 plic_req_o,
    output periph_pkg::apb_req_t                 gpio_req_o,
    output periph_pkg::apb_req_t                 timer_req_o,
    input  logic [periph_pkg::DataWidth-1:0]     plic_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0]     gpio_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0]     timer_rdata_i
);

    logic [periph_pkg::SlotMsb-periph_pkg::SlotLsb:0] slot;
    logic hit_plic;
    logic hit_gpio;
    logic hit_timer;

    assign slot      = bus_req_i.addr[periph_pkg::SlotMsb:periph_pkg::SlotLsb];
    assign hit_plic  = (slot == periph_pkg::SlotPlic);
    assign hit_gpio  = (slot == periph_pkg::SlotGpio);
    assign hit_timer = (slot == periph_pkg::SlotTimer);

    // --------------------
    // Request fan-out
    // --------------------
    always_comb begin
        plic_req_o      = bus_req_i;
        gpio_req_o      = bus_req_i;
        timer_req_o     = bus_req_i;
        plic_req_o.sel  = bus_req_i.sel & hit_plic;
        gpio_req_o.sel  = bus_req_i.sel & hit_gpio;
        timer_req_o.sel = bus_req_i.sel & hit_timer;
    end

    // --------------------
    // Response
    // --------------------
    always_comb begin
        bus_resp_o.ready  = 1'b1; // Zero-wait slaves
        bus_resp_o.slverr = 1'b0;
        case (slot)
            periph_pkg::SlotPlic:  bus_resp_o.rdata = plic_rdata_i;
            periph_pkg::SlotGpio:  bus_resp_o.rdata = gpio_rdata_i;
            periph_pkg::SlotTimer: bus_resp_o.rdata = timer_rdata_i;
            default: begin
                bus_resp_o.rdata  = periph_pkg::ErrorData;
                bus_resp_o.slverr = bus_req_i.sel & bus_req_i.enable;
            end
        endcase
    end

    // Never more than one slave selected
    a_onehot_sel: assert final ($onehot0({plic_req_o.sel, gpio_req_o.sel, timer_req_o.sel}))
        else $error("more than one peripheral selected");

endmodule

/* periph_plic.sv */
// Level-triggered interrupt controller, PLIC style
// Gateways, per-source priority, per-target enable/threshold and claim/complete

module periph_plic (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  periph_pkg::apb_req_t                 req_i,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    input  logic                                 ext_irq_i,
    input  logic [periph_pkg::NumTimers-1:0]     timer_irq_i,
    output logic [periph_pkg::NumTargets-1:0]    irq_o
);

    logic [11:0] offset;
    logic        wr_en;
    logic        rd_en;

    logic [periph_pkg::NumSources:1] src;
    logic [periph_pkg::NumSources:1] pending_q;
    logic [periph_pkg::NumSources:1] in_service_q;
    logic [periph_pkg::NumSources:1][periph_pkg::PrioWidth-1:0] prio_q;

    logic [periph_pkg::NumTargets-1:0][periph_pkg::NumSources:1]   enable_q;
    logic [periph_pkg::NumTargets-1:0][periph_pkg::PrioWidth-1:0]  thresh_q;
    logic [periph_pkg::NumTargets-1:0][periph_pkg::PrioWidth-1:0]  best_prio;
    logic [periph_pkg::NumTargets-1:0][periph_pkg::SrcIdWidth-1:0] best_id;
    logic [periph_pkg::NumTargets-1:0] claim_rd;
    logic [periph_pkg::NumTargets-1:0] complete_wr;
    logic [periph_pkg::NumTargets-1:0] irq_q;
    logic [periph_pkg::SrcIdWidth-1:0] complete_id;

    assign offset      = {req_i.addr[11:2], 2'b00};
    assign wr_en       = req_i.sel & req_i.enable & req_i.write;
    assign rd_en       = req_i.sel & req_i.enable & ~req_i.write;
    assign complete_id = req_i.wdata[periph_pkg::SrcIdWidth-1:0];

    // Source mapping
    assign src[periph_pkg::SrcExt]    = ext_irq_i;
    assign src[periph_pkg::SrcTimer0] = timer_irq_i[0];
    assign src[periph_pkg::SrcTimer1] = timer_irq_i[1];

    always_comb begin
        for (int t = 0; t < periph_pkg::NumTargets; t++) begin
            claim_rd[t]    = rd_en &&
                (offset == periph_pkg::PlicClaimBase + t * periph_pkg::PlicTargetStride);
            complete_wr[t] = wr_en &&
                (offset == periph_pkg::PlicClaimBase + t * periph_pkg::PlicTargetStride);
        end
    end

    // --------------------
    // Best eligible ID
    // --------------------
    // Strict compare keeps ties on the lowest ID and skips priority 0
    always_comb begin
        for (int t = 0; t < periph_pkg::NumTargets; t++) begin
            best_id[t]   = '0;
            best_prio[t] = '0;
            for (int s = 1; s <= periph_pkg::NumSources; s++) begin
                if (pending_q[s] && enable_q[t][s] && (prio_q[s] > best_prio[t])) begin
                    best_id[t]   = periph_pkg::SrcIdWidth'(s);
                    best_prio[t] = prio_q[s];
                end
            end
        end
    end

    // --------------------
    // Registers and gateways
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
            prio_q       <= '0;
            enable_q     <= '0;
            thresh_q     <= '0;
            irq_q        <= '0;
        end else begin
            for (int s = 1; s <= periph_pkg::NumSources; s++) begin
                if (src[s] && !pending_q[s] && !in_service_q[s]) begin
                    pending_q[s] <= 1'b1;
                end
                if (wr_en && (offset == periph_pkg::PlicPrioBase + 4 * s)) begin
                    prio_q[s] <= req_i.wdata[periph_pkg::PrioWidth-1:0];
                end
            end
            for (int t = 0; t < periph_pkg::NumTargets; t++) begin
                if (claim_rd[t] && (best_id[t] != '0)) begin
                    pending_q[best_id[t]]    <= 1'b0;
                    in_service_q[best_id[t]] <= 1'b1;
                end
                if (complete_wr[t] && (complete_id != '0)) begin
                    in_service_q[complete_id] <= 1'b0;
                end
                if (wr_en && (offset == periph_pkg::PlicEnableBase + 4 * t)) begin
                    enable_q[t] <= req_i.wdata[periph_pkg::NumSources:1];
                end
                if (wr_en && (offset == periph_pkg::PlicThreshBase +
                              t * periph_pkg::PlicTargetStride)) begin
                    thresh_q[t] <= req_i.wdata[periph_pkg::PrioWidth-1:0];
                end
                irq_q[t] <= (best_prio[t] > thresh_q[t]);
            end
        end
    end

    assign irq_o = irq_q;

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0; // Unmapped offsets read zero
        for (int s = 1; s <= periph_pkg::NumSources; s++) begin
            if (offset == periph_pkg::PlicPrioBase + 4 * s) begin
                rdata_o[periph_pkg::PrioWidth-1:0] = prio_q[s];
            end
        end
        if (offset == periph_pkg::PlicPendingOff) begin
            rdata_o[periph_pkg::NumSources:1] = pending_q;
        end
        for (int t = 0; t < periph_pkg::NumTargets; t++) begin
            if (offset == periph_pkg::PlicEnableBase + 4 * t) begin
                rdata_o[periph_pkg::NumSources:1] = enable_q[t];
            end
            if (offset == periph_pkg::PlicThreshBase + t * periph_pkg::PlicTargetStride) begin
                rdata_o[periph_pkg::PrioWidth-1:0] = thresh_q[t];
            end
            if (offset == periph_pkg::PlicClaimBase + t * periph_pkg::PlicTargetStride) begin
                rdata_o[periph_pkg::SrcIdWidth-1:0] = best_id[t];
            end
        end
    end

    for (genvar t = 0; t < periph_pkg::NumTargets; t++) begin : gen_target_checks
        // Claimed ID as it leaves on the bus
        a_claim_range: assert property (@(posedge clk_i) disable iff (rst_i)
            claim_rd[t] |-> (rdata_o <= periph_pkg::NumSources));

        // Registered irq follows the enables of the cycle before
        a_irq_needs_enable: assert property (@(posedge clk_i) disable iff (rst_i)
            irq_q[t] |-> ($past(enable_q[t]) != '0));
    end

endmodule

/* periph_timer.sv */
// Compare timers
// Each timer counts while enabled, wraps on compare and flags a sticky status bit

module periph_timer (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  periph_pkg::apb_req_t                 req_i,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    output logic [periph_pkg::NumTimers-1:0]     irq_o
);

    logic [11:0] offset;
    logic        wr_en;

    logic [periph_pkg::NumTimers-1:0][periph_pkg::DataWidth-1:0] count_q;
    logic [periph_pkg::NumTimers-1:0][periph_pkg::DataWidth-1:0] compare_q;
    logic [periph_pkg::NumTimers-1:0] enable_q;
    logic [periph_pkg::NumTimers-1:0] status_q;
    logic [periph_pkg::NumTimers-1:0] match;

    assign offset = {req_i.addr[11:2], 2'b00};
    assign wr_en  = req_i.sel & req_i.enable & req_i.write;

    always_comb begin
        for (int t = 0; t < periph_pkg::NumTimers; t++) begin
            match[t] = enable_q[t] && (count_q[t] == compare_q[t]);
        end
    end

    // --------------------
    // Counters and registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= '0;
            status_q  <= '0;
        end else begin
            for (int t = 0; t < periph_pkg::NumTimers; t++) begin
                // Software write beats the counter
                if (wr_en && (offset == t * periph_pkg::TimerStride +
                              periph_pkg::TimerCountOff)) begin
                    count_q[t] <= req_i.wdata;
                end else if (match[t]) begin
                    count_q[t] <= '0;
                end else if (enable_q[t]) begin
                    count_q[t] <= count_q[t] + 1'b1;
                end

                if (wr_en && (offset == t * periph_pkg::TimerStride +
                              periph_pkg::TimerCompareOff)) begin
                    compare_q[t] <= req_i.wdata;
                end
                if (wr_en && (offset == t * periph_pkg::TimerStride +
                              periph_pkg::TimerCtrlOff)) begin
                    enable_q[t] <= req_i.wdata[0];
                end

                if (match[t]) begin
                    status_q[t] <= 1'b1; // Set wins over clear
                end else if (wr_en && req_i.wdata[0] &&
                             (offset == t * periph_pkg::TimerStride +
                              periph_pkg::TimerStatusOff)) begin
                    status_q[t] <= 1'b0;
                end
            end
        end
    end

    assign irq_o = status_q;

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        for (int t = 0; t < periph_pkg::NumTimers; t++) begin
            case (offset)
                t * periph_pkg::TimerStride + periph_pkg::TimerCountOff:   rdata_o = count_q[t];
                t * periph_pkg::TimerStride + periph_pkg::TimerCompareOff: rdata_o = compare_q[t];
                t * periph_pkg::TimerStride + periph_pkg::TimerCtrlOff:    rdata_o[0] = enable_q[t];
                t * periph_pkg::TimerStride + periph_pkg::TimerStatusOff:  rdata_o[0] = status_q[t];
                default: ;
            endcase
        end
    end

    for (genvar t = 0; t < periph_pkg::NumTimers; t++) begin : gen_timer_checks
        a_status_when_enabled: assert property (@(posedge clk_i) disable iff (rst_i)
            $rose(status_q[t]) |-> $past(enable_q[t]));
    end

endmodule

/* periph_gpio.sv */
// GPIO block
// LED output register plus a two-flop synchroniser on the switch inputs

module periph_gpio (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  periph_pkg::apb_req_t                 req_i,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    output logic [periph_pkg::NumGpio-1:0]       leds_o,
    input  logic [periph_pkg::NumGpio-1:0]       dip_switches_i
);

    logic [11:0] offset;
    logic        wr_en;

    logic [periph_pkg::NumGpio-1:0] leds_q;
    logic [periph_pkg::NumGpio-1:0] sw_meta_q;
    logic [periph_pkg::NumGpio-1:0] sw_sync_q;

    assign offset = {req_i.addr[11:2], 2'b00};
    assign wr_en  = req_i.sel & req_i.enable & req_i.write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            leds_q    <= '0;
            sw_meta_q <= '0;
            sw_sync_q <= '0;
        end else begin
            if (wr_en && (offset == periph_pkg::GpioOutOff)) begin
                leds_q <= req_i.wdata[periph_pkg::NumGpio-1:0];
            end
            sw_meta_q <= dip_switches_i; // Switches are asynchronous
            sw_sync_q <= sw_meta_q;
        end
    end

    assign leds_o = leds_q;

    always_comb begin
        rdata_o = '0;
        if (offset == periph_pkg::GpioOutOff) begin
            rdata_o[periph_pkg::NumGpio-1:0] = leds_q;
        end else if (offset == periph_pkg::GpioInOff) begin
            rdata_o[periph_pkg::NumGpio-1:0] = sw_sync_q;
        end
    end

endmodule

/* periph_subsystem.sv */
// Peripheral subsystem top level
// One APB-style slave port fanned out to the interrupt controller, GPIO and timers

module periph_subsystem (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  periph_pkg::apb_req_t                 bus_req_i,
    output periph_pkg::apb_resp_t                bus_resp_o,
    input  logic                                 ext_irq_i,
    output logic [periph_pkg::NumTargets-1:0]    irq_o,
    output logic [periph_pkg::NumGpio-1:0]       leds_o,
    input  logic [periph_pkg::NumGpio-1:0]       dip_switches_i
);

    periph_pkg::apb_req_t                plic_req;
    periph_pkg::apb_req_t                gpio_req;
    periph_pkg::apb_req_t                timer_req;
    logic [periph_pkg::DataWidth-1:0]    plic_rdata;
    logic [periph_pkg::DataWidth-1:0]    gpio_rdata;
    logic [periph_pkg::DataWidth-1:0]    timer_rdata;
    logic [periph_pkg::NumTimers-1:0]    timer_irq;

    periph_apb_decode i_decode (
        .bus_req_i     ( bus_req_i   ),
        .bus_resp_o    ( bus_resp_o  ),
        .plic_req_o    ( plic_req    ),
        .gpio_req_o    ( gpio_req    ),
        .timer_req_o   ( timer_req   ),
        .plic_rdata_i  ( plic_rdata  ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata )
    );

    periph_plic i_plic (
        .clk_i       ( clk_i      ),
        .rst_i       ( rst_i      ),
        .req_i       ( plic_req   ),
        .rdata_o     ( plic_rdata ),
        .ext_irq_i   ( ext_irq_i  ),
        .timer_irq_i ( timer_irq  ),
        .irq_o       ( irq_o      )
    );

    periph_gpio i_gpio (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .req_i          ( gpio_req       ),
        .rdata_o        ( gpio_rdata     ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i )
    );

    periph_timer i_timer (
        .clk_i   ( clk_i       ),
        .rst_i   ( rst_i       ),
        .req_i   ( timer_req   ),
        .rdata_o ( timer_rdata ),
        .irq_o   ( timer_irq   ) // Sources 2 and 3
    );

endmodule

/* tb_periph_bus_tasks.svh */
// Bus transfer tasks and per-test reporting for the peripheral subsystem testbench
// Included inside the testbench module, uses its bus signals and counters

`ifndef TB_PERIPH_BUS_TASKS_SVH
`define TB_PERIPH_BUS_TASKS_SVH

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("FAIL %s (%s): expected 0x%08h, actual 0x%08h", cur_test, what, expected, actual);
        errors++;
    end
endtask

// Setup cycle, access cycle, then back to idle
task automatic transfer(input logic wr, input logic [periph_pkg::AddrWidth-1:0] addr,
                        input logic [periph_pkg::DataWidth-1:0] wdata,
                        output logic [periph_pkg::DataWidth-1:0] rdata, output logic err);
    periph_pkg::apb_req_t req;
    req       = '0;
    req.sel   = 1'b1;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge clk);
    bus_req <= req;
    @(posedge clk);
    bus_req.enable <= 1'b1;
    @(negedge clk); // Response is stable mid access cycle
    rdata = bus_resp.rdata;
    err   = bus_resp.slverr;
    @(posedge clk);
    bus_req <= '0;
endtask

task automatic write_reg(input logic [periph_pkg::AddrWidth-1:0] addr,
                         input logic [periph_pkg::DataWidth-1:0] wdata);
    logic [periph_pkg::DataWidth-1:0] rdata;
    logic                             err;
    transfer(1'b1, addr, wdata, rdata, err);
    check_value("write slverr", '0, 32'(err));
endtask

task automatic read_reg(input logic [periph_pkg::AddrWidth-1:0] addr,
                        output logic [periph_pkg::DataWidth-1:0] rdata);
    logic err;
    transfer(1'b0, addr, '0, rdata, err);
    check_value("read slverr", '0, 32'(err));
endtask

task automatic expect_read(input string what, input logic [periph_pkg::AddrWidth-1:0] addr,
                           input logic [periph_pkg::DataWidth-1:0] expected);
    logic [periph_pkg::DataWidth-1:0] rdata;
    read_reg(addr, rdata);
    check_value(what, expected, rdata);
endtask

// Unmapped slot, slverr always and the error pattern on reads
task automatic expect_error(input logic wr, input logic [periph_pkg::AddrWidth-1:0] addr,
                            input logic [periph_pkg::DataWidth-1:0] wdata);
    logic [periph_pkg::DataWidth-1:0] rdata;
    logic                             err;
    transfer(wr, addr, wdata, rdata, err);
    check_value("error slot slverr", 32'd1, 32'(err));
    if (!wr) begin
        check_value("error slot rdata", periph_pkg::ErrorData, rdata);
    end
endtask

task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
endtask

task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start) begin
        $display("test %-12s ok", cur_test);
    end else begin
        tests_bad++;
        $display("test %-12s %0d error(s)", cur_test, errors - errors_at_start);
    end
endtask

`endif

/* tb_periph_subsystem.sv */
// Testbench for the peripheral subsystem
// Reset state, GPIO, error slot, timer and interrupt controller tests over the bus port

module tb_periph_subsystem;

    localparam int ClkPeriod      = 40;
    localparam int ResetCycles    = 16;
    localparam int MaxXfers       = 128;
    localparam int XferCycles     = 3; // Setup, access, idle
    localparam int MaxTimerWait   = 2 * (40 + 2);
    localparam int WatchdogCycles = ResetCycles + MaxXfers * XferCycles + MaxTimerWait + 200;

    localparam int PlicBase  = int'(periph_pkg::SlotPlic) << periph_pkg::SlotLsb;
    localparam int GpioBase  = int'(periph_pkg::SlotGpio) << periph_pkg::SlotLsb;
    localparam int TimerBase = int'(periph_pkg::SlotTimer) << periph_pkg::SlotLsb;
    localparam int Pending   = PlicBase + periph_pkg::PlicPendingOff;
    localparam int Enable0   = PlicBase + periph_pkg::PlicEnableBase;
    localparam int Thresh0   = PlicBase + periph_pkg::PlicThreshBase;
    localparam int Claim0    = PlicBase + periph_pkg::PlicClaimBase;
    localparam int Status0   = TimerBase + periph_pkg::TimerStatusOff;

    logic                              clk;
    logic                              rst;
    periph_pkg::apb_req_t              bus_req;
    periph_pkg::apb_resp_t             bus_resp;
    logic                              ext_irq;
    logic [periph_pkg::NumTargets-1:0] irq;
    logic [periph_pkg::NumGpio-1:0]    leds;
    logic [periph_pkg::NumGpio-1:0]    dip_switches;

    string cur_test = "none";
    int    errors = 0;
    int    checks = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    int    seed = 27734;

    periph_subsystem dut_i (
        .clk_i          ( clk          ),
        .rst_i          ( rst          ),
        .bus_req_i      ( bus_req      ),
        .bus_resp_o     ( bus_resp     ),
        .ext_irq_i      ( ext_irq      ),
        .irq_o          ( irq          ),
        .leds_o         ( leds         ),
        .dip_switches_i ( dip_switches )
    );

    `include "tb_periph_bus_tasks.svh"

    task automatic wait_for_irq(input int target, input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while ((irq[target] !== level) && (n < max_cycles)) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (irq[target] === level) else begin
            $display("%s: irq_o[%0d] did not reach %b within %0d cycles",
                     cur_test, target, level, max_cycles);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog: run still busy after %0d cycles in test %s", WatchdogCycles, cur_test);
        $display("tests failed");
        $finish;
    end

    // --------------------
    // Always-on checks
    a_ready_high: assert property (@(posedge clk) disable iff (rst) bus_resp.ready)
        else begin
            $display("bus ready went low in test %s", cur_test);
            errors++;
        end
    a_slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        bus_resp.slverr |-> (bus_req.sel && bus_req.enable))
        else begin
            $display("slverr raised outside an access cycle in test %s", cur_test);
            errors++;
        end
    a_target1_quiet: assert property (@(posedge clk) disable iff (rst) !irq[1])
        else begin
            $display("irq_o[1] went high although target 1 has no enables");
            errors++;
        end

    initial begin
        logic [periph_pkg::DataWidth-1:0] word;
        logic [periph_pkg::DataWidth-1:0] rdata;
        logic [periph_pkg::NumGpio-1:0]   sw;
        int                               cmp;

        rst          = 1'b1;
        bus_req      = '0;
        ext_irq      = 1'b0;
        dip_switches = '0;
        word         = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        @(negedge clk);
        check_value("irq_o", '0, 32'(irq));
        check_value("leds_o", '0, 32'(leds));
        for (int s = 1; s <= periph_pkg::NumSources; s++) begin
            expect_read("priority", PlicBase + periph_pkg::PlicPrioBase + 4 * s, '0);
        end
        expect_read("pending", Pending, '0);
        for (int t = 0; t < periph_pkg::NumTargets; t++) begin
            expect_read("enable", Enable0 + 4 * t, '0);
            expect_read("threshold", Thresh0 + t * periph_pkg::PlicTargetStride, '0);
            expect_read("claim", Claim0 + t * periph_pkg::PlicTargetStride, '0);
        end
        expect_read("led register", GpioBase + periph_pkg::GpioOutOff, '0);
        expect_read("switch register", GpioBase + periph_pkg::GpioInOff, '0);
        for (int t = 0; t < periph_pkg::NumTimers; t++) begin
            for (int r = 0; r < 4; r++) begin
                expect_read("timer register", TimerBase + t * periph_pkg::TimerStride + 4 * r, '0);
            end
        end
        finish_test();

        start_test("gpio");
        for (int i = 0; i < 8; i++) begin
            word = $random(seed);
            write_reg(GpioBase + periph_pkg::GpioOutOff, word);
            @(negedge clk);
            check_value("leds_o", 32'(word[periph_pkg::NumGpio-1:0]), 32'(leds));
            expect_read("led readback", GpioBase + periph_pkg::GpioOutOff,
                        32'(word[periph_pkg::NumGpio-1:0]));
            sw = $random(seed);
            @(posedge clk);
            dip_switches <= sw;
            repeat (2) @(posedge clk); // Two-flop synchroniser
            expect_read("switches", GpioBase + periph_pkg::GpioInOff, 32'(sw));
        end
        finish_test();

        start_test("error_slot");
        for (int s = 3; s < 16; s++) begin
            expect_error(1'b0, s << periph_pkg::SlotLsb, '0);
        end
        expect_error(1'b1, (5 << periph_pkg::SlotLsb) + periph_pkg::GpioOutOff, ~word);
        expect_error(1'b1, (7 << periph_pkg::SlotLsb) + periph_pkg::TimerCompareOff, 32'h55);
        check_value("leds_o kept", 32'(word[periph_pkg::NumGpio-1:0]), 32'(leds));
        expect_read("timer compare kept", TimerBase + periph_pkg::TimerCompareOff, '0);
        finish_test();

        start_test("timer");
        cmp = 5 + ({$random(seed)} % 36);
        write_reg(TimerBase + periph_pkg::TimerCompareOff, 32'(cmp));
        write_reg(TimerBase + periph_pkg::TimerCtrlOff, 32'd1);
        repeat (cmp + 2) @(posedge clk);
        expect_read("status set", Status0, 32'd1);
        for (int i = 0; i < 4; i++) begin
            read_reg(TimerBase + periph_pkg::TimerCountOff, rdata);
            checks++;
            assert (rdata <= cmp) else begin
                $display("FAIL %s (count): expected at most %0d, actual %0d", cur_test, cmp, rdata);
                errors++;
            end
        end
        write_reg(TimerBase + periph_pkg::TimerCtrlOff, '0); // Stop before clearing
        write_reg(Status0, 32'd1);
        expect_read("status cleared", Status0, '0);
        repeat (cmp + 2) @(posedge clk);
        expect_read("disabled timer 0", Status0, '0);
        expect_read("disabled timer 1", Status0 + periph_pkg::TimerStride, '0);
        finish_test();

        start_test("plic_claim");
        write_reg(PlicBase + 4 * periph_pkg::SrcExt, 32'd2);
        write_reg(Enable0, 32'(1 << periph_pkg::SrcExt));
        write_reg(Thresh0, 32'd1);
        @(posedge clk);
        ext_irq <= 1'b1;
        wait_for_irq(0, 1'b1, 8);
        check_value("irq_o[1]", '0, 32'(irq[1]));
        expect_read("claim", Claim0, 32'(periph_pkg::SrcExt));
        wait_for_irq(0, 1'b0, 4); // Source now in service
        @(posedge clk);
        ext_irq <= 1'b0;
        write_reg(Claim0, 32'(periph_pkg::SrcExt));
        repeat (3) @(negedge clk);
        check_value("irq_o[0] after complete", '0, 32'(irq[0]));
        // Timer 0 status from the timer test is still latched as pending
        expect_read("pending", Pending, 32'(1 << periph_pkg::SrcTimer0));
        finish_test();

        start_test("plic_prio");
        write_reg(PlicBase + 4 * periph_pkg::SrcExt, 32'd1);
        write_reg(PlicBase + 4 * periph_pkg::SrcTimer0, 32'd3);
        write_reg(Enable0, 32'((1 << periph_pkg::SrcExt) | (1 << periph_pkg::SrcTimer0)));
        @(posedge clk);
        ext_irq <= 1'b1;
        wait_for_irq(0, 1'b1, 8);
        expect_read("both pending", Pending,
                    32'((1 << periph_pkg::SrcExt) | (1 << periph_pkg::SrcTimer0)));
        expect_read("first claim", Claim0, 32'(periph_pkg::SrcTimer0));
        expect_read("second claim", Claim0, 32'(periph_pkg::SrcExt));
        write_reg(Thresh0, 32'(periph_pkg::MaxPriority));
        write_reg(PlicBase + 4 * periph_pkg::SrcExt, 32'(periph_pkg::MaxPriority));
        write_reg(Claim0, 32'(periph_pkg::SrcTimer0));
        write_reg(Claim0, 32'(periph_pkg::SrcExt)); // ext still high, pends again
        repeat (4) @(negedge clk);
        expect_read("pending under threshold", Pending, 32'(1 << periph_pkg::SrcExt));
        check_value("irq_o[0] under threshold", '0, 32'(irq[0]));
        finish_test();

        $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* periph_subsystem.f */
+incdir+.
periph_pkg.sv
periph_apb_decode.sv
periph_plic.sv
periph_timer.sv
periph_gpio.sv
periph_subsystem.sv
tb_periph_subsystem.sv

/* Bender.yml */
package:
  name: periph_subsystem

sources:
  - periph_pkg.sv
  - periph_apb_decode.sv
  - periph_plic.sv
  - periph_timer.sv
  - periph_gpio.sv
  - periph_subsystem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_periph_subsystem.sv
